/* include/rv_decoder_settings.svh */
`ifndef RV_DECODER_SETTINGS_SVH
`define RV_DECODER_SETTINGS_SVH

// RV64 datapath width, also the width of the extended immediate
`define RV_XLEN 64

// Base ISA instruction width, no compressed forms here
`define RV_ILEN 32

// Architectural register index width, x0..x31
`define RV_REG_W 5

`endif

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_settings.svh"

module rv_decoder (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire                      inst_valid,
    input  wire [`RV_ILEN-1:0]       inst,
    output logic                     dec_valid,
    output rv_decoder_pkg::dec_uop_t dec
);

    rv_decoder_pkg::dec_ctrl_t ctrl;

    // Pure table lookup, no state
    rv_op_decode op_decode_i (
        .inst (inst),
        .ctrl (ctrl)
    );

    // Immediates, register fields and the output flops
    rv_operand_stage operand_stage_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ctrl       (ctrl),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

endmodule

`default_nettype wire

/* rtl/rv_decoder_pkg.sv */
`default_nettype none

`include "rv_decoder_settings.svh"

package rv_decoder_pkg;

    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_MISC_MEM  = 7'b0001111,
        OPC_SYSTEM    = 7'b1110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // Unsigned compares reuse BLT/BGE with is_unsigned
    typedef enum logic [2:0] {
        CX_NONE, CX_JAL, CX_JALR, CX_BEQ, CX_BNE, CX_BLT, CX_BGE
    } cx_op_e;

    typedef enum logic [3:0] {
        MDU_NONE, MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU,
        MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU,
        MDU_MULW, MDU_DIVW, MDU_DIVUW, MDU_REMW, MDU_REMUW
    } mdu_op_e;

    typedef enum logic [2:0] {
        LS_NONE, LS_B, LS_H, LS_W, LS_D
    } ls_size_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef struct packed {
        imm_fmt_e imm_fmt;
        alu_op_e  alu_op;
        cx_op_e   cx_op;
        mdu_op_e  mdu_op;
        ls_size_e ls_size;
        logic     is_unsigned;
        logic     is_word;
        logic     is_imm;
        logic     is_load;
        logic     is_store;
        logic     need_to_wb;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  imm;          // Already extended to XLEN
        alu_op_e              alu_op;
        cx_op_e               cx_op;
        mdu_op_e              mdu_op;
        ls_size_e             ls_size;
        logic                 is_unsigned;
        logic                 is_word;
        logic                 is_imm;
        logic                 is_load;
        logic                 is_store;
        logic                 need_to_wb;
    } dec_uop_t;

endpackage

`default_nettype wire

/* rtl/rv_op_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_settings.svh"

module rv_op_decode (
    input  wire [`RV_ILEN-1:0]       inst,
    output rv_decoder_pkg::dec_ctrl_t ctrl
);

    rv_decoder_pkg::rv_opcode_e opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    rv_decoder_pkg::dec_ctrl_t  raw;
    logic                       legal;

    assign opcode = rv_decoder_pkg::rv_opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        raw   = '0;
        legal = 1'b0;
        case (opcode)
            rv_decoder_pkg::OPC_LUI: begin
                raw.imm_fmt    = rv_decoder_pkg::IMM_U;
                raw.alu_op     = rv_decoder_pkg::ALU_LUI;
                raw.need_to_wb = 1'b1;
                legal          = 1'b1;
            end
            rv_decoder_pkg::OPC_AUIPC: begin
                raw.imm_fmt    = rv_decoder_pkg::IMM_U;
                raw.alu_op     = rv_decoder_pkg::ALU_AUIPC;
                raw.need_to_wb = 1'b1;
                legal          = 1'b1;
            end
            rv_decoder_pkg::OPC_JAL: begin
                raw.imm_fmt    = rv_decoder_pkg::IMM_J;
                raw.cx_op      = rv_decoder_pkg::CX_JAL;
                raw.need_to_wb = 1'b1;
                legal          = 1'b1;
            end
            rv_decoder_pkg::OPC_JALR: begin
                raw.imm_fmt    = rv_decoder_pkg::IMM_I;
                raw.cx_op      = rv_decoder_pkg::CX_JALR;
                raw.need_to_wb = 1'b1;
                legal          = (funct3 == 3'b000);
            end
            rv_decoder_pkg::OPC_BRANCH: begin
                raw.imm_fmt     = rv_decoder_pkg::IMM_B;
                raw.is_unsigned = funct3[1];       // BLTU, BGEU
                legal           = 1'b1;
                case (funct3)
                    3'b000:         raw.cx_op = rv_decoder_pkg::CX_BEQ;
                    3'b001:         raw.cx_op = rv_decoder_pkg::CX_BNE;
                    3'b100, 3'b110: raw.cx_op = rv_decoder_pkg::CX_BLT;
                    3'b101, 3'b111: raw.cx_op = rv_decoder_pkg::CX_BGE;
                    default:        legal     = 1'b0;
                endcase
            end
            rv_decoder_pkg::OPC_LOAD: begin
                raw.imm_fmt     = rv_decoder_pkg::IMM_I;
                raw.is_load     = 1'b1;
                raw.need_to_wb  = 1'b1;
                raw.is_unsigned = funct3[2];       // LBU, LHU, LWU
                legal           = (funct3 != 3'b111);
                case (funct3[1:0])
                    2'b00:   raw.ls_size = rv_decoder_pkg::LS_B;
                    2'b01:   raw.ls_size = rv_decoder_pkg::LS_H;
                    2'b10:   raw.ls_size = rv_decoder_pkg::LS_W;
                    default: raw.ls_size = rv_decoder_pkg::LS_D;
                endcase
            end
            rv_decoder_pkg::OPC_STORE: begin
                raw.imm_fmt  = rv_decoder_pkg::IMM_S;
                raw.is_store = 1'b1;
                legal        = !funct3[2];
                case (funct3[1:0])
                    2'b00:   raw.ls_size = rv_decoder_pkg::LS_B;
                    2'b01:   raw.ls_size = rv_decoder_pkg::LS_H;
                    2'b10:   raw.ls_size = rv_decoder_pkg::LS_W;
                    default: raw.ls_size = rv_decoder_pkg::LS_D;
                endcase
            end
            rv_decoder_pkg::OPC_OP_IMM: begin
                raw.imm_fmt    = rv_decoder_pkg::IMM_I;
                raw.is_imm     = 1'b1;
                raw.need_to_wb = 1'b1;
                legal          = 1'b1;
                case (funct3)
                    3'b000: raw.alu_op = rv_decoder_pkg::ALU_ADD;
                    3'b010: raw.alu_op = rv_decoder_pkg::ALU_SLT;
                    3'b011: begin
                        raw.alu_op      = rv_decoder_pkg::ALU_SLT;
                        raw.is_unsigned = 1'b1;
                    end
                    3'b100: raw.alu_op = rv_decoder_pkg::ALU_XOR;
                    3'b110: raw.alu_op = rv_decoder_pkg::ALU_OR;
                    3'b111: raw.alu_op = rv_decoder_pkg::ALU_AND;
                    // funct7[0] is shamt[5] in the 64-bit shifts
                    3'b001: begin
                        raw.alu_op = rv_decoder_pkg::ALU_SLL;
                        legal      = (funct7[6:1] == 6'b000000);
                    end
                    3'b101: begin
                        raw.alu_op = funct7[5] ? rv_decoder_pkg::ALU_SRA
                                               : rv_decoder_pkg::ALU_SRL;
                        legal      = ({funct7[6], funct7[4:1]} == 5'b00000);
                    end
                    default: legal = 1'b0;
                endcase
            end
            rv_decoder_pkg::OPC_OP: begin
                raw.need_to_wb = 1'b1;
                legal          = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: raw.alu_op = rv_decoder_pkg::ALU_ADD;
                    10'b0100000_000: raw.alu_op = rv_decoder_pkg::ALU_SUB;
                    10'b0000000_001: raw.alu_op = rv_decoder_pkg::ALU_SLL;
                    10'b0000000_010: raw.alu_op = rv_decoder_pkg::ALU_SLT;
                    10'b0000000_011: begin
                        raw.alu_op      = rv_decoder_pkg::ALU_SLT;
                        raw.is_unsigned = 1'b1;
                    end
                    10'b0000000_100: raw.alu_op = rv_decoder_pkg::ALU_XOR;
                    10'b0000000_101: raw.alu_op = rv_decoder_pkg::ALU_SRL;
                    10'b0100000_101: raw.alu_op = rv_decoder_pkg::ALU_SRA;
                    10'b0000000_110: raw.alu_op = rv_decoder_pkg::ALU_OR;
                    10'b0000000_111: raw.alu_op = rv_decoder_pkg::ALU_AND;
                    10'b0000001_000: raw.mdu_op = rv_decoder_pkg::MDU_MUL;
                    10'b0000001_001: raw.mdu_op = rv_decoder_pkg::MDU_MULH;
                    10'b0000001_010: raw.mdu_op = rv_decoder_pkg::MDU_MULHSU;
                    10'b0000001_011: raw.mdu_op = rv_decoder_pkg::MDU_MULHU;
                    10'b0000001_100: raw.mdu_op = rv_decoder_pkg::MDU_DIV;
                    10'b0000001_101: raw.mdu_op = rv_decoder_pkg::MDU_DIVU;
                    10'b0000001_110: raw.mdu_op = rv_decoder_pkg::MDU_REM;
                    10'b0000001_111: raw.mdu_op = rv_decoder_pkg::MDU_REMU;
                    default:         legal      = 1'b0;
                endcase
            end
            rv_decoder_pkg::OPC_OP_IMM_32: begin
                raw.imm_fmt    = rv_decoder_pkg::IMM_I;
                raw.is_imm     = 1'b1;
                raw.is_word    = 1'b1;
                raw.need_to_wb = 1'b1;
                legal          = 1'b1;
                casez ({funct7, funct3})
                    10'b???????_000: raw.alu_op = rv_decoder_pkg::ALU_ADD;
                    10'b0000000_001: raw.alu_op = rv_decoder_pkg::ALU_SLL;
                    10'b0000000_101: raw.alu_op = rv_decoder_pkg::ALU_SRL;
                    10'b0100000_101: raw.alu_op = rv_decoder_pkg::ALU_SRA;
                    default:         legal      = 1'b0;
                endcase
            end
            rv_decoder_pkg::OPC_OP_32: begin
                raw.is_word    = 1'b1;
                raw.need_to_wb = 1'b1;
                legal          = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: raw.alu_op = rv_decoder_pkg::ALU_ADD;
                    10'b0100000_000: raw.alu_op = rv_decoder_pkg::ALU_SUB;
                    10'b0000000_001: raw.alu_op = rv_decoder_pkg::ALU_SLL;
                    10'b0000000_101: raw.alu_op = rv_decoder_pkg::ALU_SRL;
                    10'b0100000_101: raw.alu_op = rv_decoder_pkg::ALU_SRA;
                    10'b0000001_000: raw.mdu_op = rv_decoder_pkg::MDU_MULW;
                    10'b0000001_100: raw.mdu_op = rv_decoder_pkg::MDU_DIVW;
                    10'b0000001_101: raw.mdu_op = rv_decoder_pkg::MDU_DIVUW;
                    10'b0000001_110: raw.mdu_op = rv_decoder_pkg::MDU_REMW;
                    10'b0000001_111: raw.mdu_op = rv_decoder_pkg::MDU_REMUW;
                    default:         legal      = 1'b0;
                endcase
            end
            // FENCE and ECALL/EBREAK carry no micro-op in this core
            rv_decoder_pkg::OPC_MISC_MEM,
            rv_decoder_pkg::OPC_SYSTEM: legal = 1'b0;
            default: legal = 1'b0;
        endcase
    end

    assign ctrl = legal ? raw : '0;                // Undefined encodings decode to nothing

endmodule

`default_nettype wire

/* rtl/rv_operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_settings.svh"

module rv_operand_stage (
    input  wire                       clock,
    input  wire                       arst_n,
    input  wire                       inst_valid,
    input  wire [`RV_ILEN-1:0]        inst,
    input  wire rv_decoder_pkg::dec_ctrl_t ctrl,
    output logic                      dec_valid,
    output rv_decoder_pkg::dec_uop_t  dec
);

    logic [`RV_XLEN-1:0]      imm_i;
    logic [`RV_XLEN-1:0]      imm_s;
    logic [`RV_XLEN-1:0]      imm_b;
    logic [`RV_XLEN-1:0]      imm_u;
    logic [`RV_XLEN-1:0]      imm_j;
    logic [`RV_XLEN-1:0]      imm_sel;
    rv_decoder_pkg::dec_uop_t uop_next;

    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7],
                    inst[30:25], inst[11:8], 1'b0};       // Halfword aligned
    assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12],
                    inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (ctrl.imm_fmt)
            rv_decoder_pkg::IMM_I:    imm_sel = imm_i;
            rv_decoder_pkg::IMM_S:    imm_sel = imm_s;
            rv_decoder_pkg::IMM_B:    imm_sel = imm_b;
            rv_decoder_pkg::IMM_U:    imm_sel = imm_u;
            rv_decoder_pkg::IMM_J:    imm_sel = imm_j;
            rv_decoder_pkg::IMM_NONE: imm_sel = '0;    // R-type and undefined
            default:                  imm_sel = '0;
        endcase
    end

    always_comb begin
        uop_next.rs1         = inst[19:15];
        uop_next.rs2         = inst[24:20];
        uop_next.rd          = inst[11:7];
        uop_next.imm         = imm_sel;
        uop_next.alu_op      = ctrl.alu_op;
        uop_next.cx_op       = ctrl.cx_op;
        uop_next.mdu_op      = ctrl.mdu_op;
        uop_next.ls_size     = ctrl.ls_size;
        uop_next.is_unsigned = ctrl.is_unsigned;
        uop_next.is_word     = ctrl.is_word;
        uop_next.is_imm      = ctrl.is_imm;
        uop_next.is_load     = ctrl.is_load;
        uop_next.is_store    = ctrl.is_store;
        uop_next.need_to_wb  = ctrl.need_to_wb;
    end

    // Pipeline boundary between decode and issue
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= inst_valid;
            if (inst_valid) begin
                dec <= uop_next;                       // Hold last bundle on idle cycles
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the decoder testbench, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module rv_decoder_tb -o rv_decoder_sim \
    && ./obj_dir/rv_decoder_sim | tee /dev/stderr | grep -q "^No errors$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* src.f */
+incdir+include
rtl/rv_decoder_pkg.sv
rtl/rv_op_decode.sv
rtl/rv_operand_stage.sv
rtl/rv_decoder.sv
tests/rv_decoder_sva.sv
tests/rv_decoder_tb.sv

/* tests/rv_decoder_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_sva (
    input wire                           clock,
    input wire                           arst_n,
    input wire                           inst_valid,
    input wire                           dec_valid,
    input wire rv_decoder_pkg::dec_uop_t dec
);

    // One stage of latency on the strobe
    valid_latency: assert property (@(posedge clock) disable iff (!arst_n)
        dec_valid == $past(inst_valid))
        else $error("dec_valid does not follow inst_valid by one cycle");

    load_store_excl: assert property (@(posedge clock) disable iff (!arst_n)
        !(dec.is_load && dec.is_store))
        else $error("is_load and is_store both set");

    // At most one functional unit per micro-op
    single_unit: assert property (@(posedge clock) disable iff (!arst_n)
        dec_valid |-> ($countones({dec.alu_op != rv_decoder_pkg::ALU_NONE,
                                   dec.cx_op != rv_decoder_pkg::CX_NONE,
                                   dec.mdu_op != rv_decoder_pkg::MDU_NONE}) <= 1))
        else $error("more than one operation field set");

    reset_quiet: assert property (@(posedge clock) !arst_n |-> !dec_valid)
        else $error("dec_valid high during reset");

endmodule

bind rv_decoder rv_decoder_sva sva_i (
    .clock      (clock),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .dec_valid  (dec_valid),
    .dec        (dec)
);

`default_nettype wire

/* tests/rv_decoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_settings.svh"

module rv_decoder_tb;

    localparam int MAX_VEC = 128;
    localparam int N_FIELD = 16;

    logic                     clock;
    logic                     arst_n;
    logic                     inst_valid;
    logic [`RV_ILEN-1:0]      inst;
    logic                     dec_valid;
    rv_decoder_pkg::dec_uop_t dec;

    logic [63:0] vec [MAX_VEC][N_FIELD];  // valid, inst, then expected fields
    int          n_vec;
    int          cycles;
    int          cycle_limit;

    rv_decoder dut_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    always #50 clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        if (exp_val !== act_val) begin
            $display("** Error at %0d ns: %s expected %0h, actual %0h",
                     $time, name, exp_val, act_val);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    code;
        string line;
        fd    = $fopen("tests/rv_decoder_tests.txt", "r");
        n_vec = 0;
        if (fd == 0) begin
            $display("Could not open the test vector file tests/rv_decoder_tests.txt");
            $display("Errors found");
            $fatal(1, "no vector file");
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() > 0 && line.substr(0, 0) != "#") begin
                code = $sscanf(line, "%h %h %d %d %d %h %d %d %d %d %d %d %d %d %d %d",
                    vec[n_vec][0], vec[n_vec][1], vec[n_vec][2], vec[n_vec][3],
                    vec[n_vec][4], vec[n_vec][5], vec[n_vec][6], vec[n_vec][7],
                    vec[n_vec][8], vec[n_vec][9], vec[n_vec][10], vec[n_vec][11],
                    vec[n_vec][12], vec[n_vec][13], vec[n_vec][14], vec[n_vec][15]);
                if (code == N_FIELD) n_vec++;
            end
        end
        $fclose(fd);
        if (n_vec == 0) begin
            $display("The test vector file holds no usable lines");
            $display("Errors found");
            $fatal(1, "empty vector file");
        end
    endtask

    task automatic drive_line(input int k);
        inst_valid = vec[k][0][0];
        inst       = vec[k][1][`RV_ILEN-1:0];
    endtask

    task automatic compare_outputs(input int k);
        check_value("dec_valid", vec[k][0], 64'(dec_valid));
        check_value("rs1", vec[k][2], 64'(dec.rs1));
        check_value("rs2", vec[k][3], 64'(dec.rs2));
        check_value("rd", vec[k][4], 64'(dec.rd));
        check_value("imm", vec[k][5], dec.imm);
        check_value("alu_op", vec[k][6], 64'(dec.alu_op));
        check_value("cx_op", vec[k][7], 64'(dec.cx_op));
        check_value("mdu_op", vec[k][8], 64'(dec.mdu_op));
        check_value("ls_size", vec[k][9], 64'(dec.ls_size));
        check_value("is_unsigned", vec[k][10], 64'(dec.is_unsigned));
        check_value("is_word", vec[k][11], 64'(dec.is_word));
        check_value("is_imm", vec[k][12], 64'(dec.is_imm));
        check_value("is_load", vec[k][13], 64'(dec.is_load));
        check_value("is_store", vec[k][14], 64'(dec.is_store));
        check_value("need_to_wb", vec[k][15], 64'(dec.need_to_wb));
    endtask

    // Run length bound
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the test did not finish", cycles);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clock       = 1'b0;
        arst_n      = 1'b0;
        inst_valid  = 1'b1;                   // Reset must keep this out of the flops
        inst        = 32'h003100B3;
        cycles      = 0;
        cycle_limit = MAX_VEC + 20;
        load_vectors();
        cycle_limit = n_vec + 20;

        @(negedge clock);
        inst_valid = 1'b0;
        inst       = '0;
        @(negedge clock);
        arst_n = 1'b1;
        check_value("dec_valid", 64'd0, 64'(dec_valid));
        check_value("dec_nonzero", 64'd0, 64'(dec != '0));

        for (int i = 0; i < n_vec; i++) begin
            if (i > 0) compare_outputs(i - 1);
            drive_line(i);
            @(negedge clock);
        end
        compare_outputs(n_vec - 1);
        inst_valid = 1'b0;
        @(negedge clock);
        check_value("dec_valid", 64'd0, 64'(dec_valid));

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/rv_decoder_tests.txt */
# valid inst(hex) rs1 rs2 rd imm(hex) alu cx mdu ls unsigned word imm load store wb
# alu 0..11 NONE ADD SUB SLL SLT XOR SRL SRA OR AND LUI AUIPC, cx/mdu/ls as enum order
1 003100B3 2 3 1 0 1 0 0 0 0 0 0 0 0 1
1 403100B3 2 3 1 0 2 0 0 0 0 0 0 0 0 1
1 003130B3 2 3 1 0 4 0 0 0 1 0 0 0 0 1
1 403150B3 2 3 1 0 7 0 0 0 0 0 0 0 0 1
1 003170B3 2 3 1 0 9 0 0 0 0 0 0 0 0 1
1 FFF10093 2 31 1 FFFFFFFFFFFFFFFF 1 0 0 0 0 0 1 0 0 1
1 00513093 2 5 1 5 4 0 0 0 1 0 1 0 0 1
1 42115093 2 1 1 421 7 0 0 0 0 0 1 0 0 1
1 00311093 2 3 1 3 3 0 0 0 0 0 1 0 0 1
1 FFE1009B 2 30 1 FFFFFFFFFFFFFFFE 1 0 0 0 0 1 1 0 0 1
1 4041509B 2 4 1 404 7 0 0 0 0 1 1 0 0 1
1 403100BB 2 3 1 0 2 0 0 0 0 1 0 0 0 1
1 003110BB 2 3 1 0 3 0 0 0 0 1 0 0 0 1
1 800000B7 0 0 1 FFFFFFFF80000000 10 0 0 0 0 0 0 0 0 1
1 12345097 8 3 1 12345000 11 0 0 0 0 0 0 0 0 1
1 00310863 2 3 16 10 0 3 0 0 0 0 0 0 0 0
1 FE316CE3 2 3 25 FFFFFFFFFFFFFFF8 0 5 0 0 1 0 0 0 0 0
1 00315863 2 3 16 10 0 6 0 0 0 0 0 0 0 0
1 FE311CE3 2 3 25 FFFFFFFFFFFFFFF8 0 4 0 0 0 0 0 0 0 0
1 FFDFF0EF 31 29 1 FFFFFFFFFFFFFFFC 0 1 0 0 0 0 0 0 0 1
1 008100E7 2 8 1 8 0 2 0 0 0 0 0 0 0 1
1 FFC10083 2 28 1 FFFFFFFFFFFFFFFC 0 0 0 1 0 0 0 1 0 1
1 FFC15083 2 28 1 FFFFFFFFFFFFFFFC 0 0 0 2 1 0 0 1 0 1
1 FFC16083 2 28 1 FFFFFFFFFFFFFFFC 0 0 0 3 1 0 0 1 0 1
1 01013083 2 16 1 10 0 0 0 4 0 0 0 1 0 1
1 00310423 2 3 8 8 0 0 0 1 0 0 0 0 1 0
1 00313423 2 3 8 8 0 0 0 4 0 0 0 0 1 0
1 FE312E23 2 3 28 FFFFFFFFFFFFFFFC 0 0 0 3 0 0 0 0 1 0
1 023100B3 2 3 1 0 0 0 1 0 0 0 0 0 0 1
1 023120B3 2 3 1 0 0 0 3 0 0 0 0 0 0 1
1 023150B3 2 3 1 0 0 0 6 0 0 0 0 0 0 1
1 023170B3 2 3 1 0 0 0 8 0 0 0 0 0 0 1
1 023100BB 2 3 1 0 0 0 9 0 0 1 0 0 0 1
1 023150BB 2 3 1 0 0 0 11 0 0 1 0 0 0 1
1 023160BB 2 3 1 0 0 0 12 0 0 1 0 0 0 1
1 403110B3 2 3 1 0 0 0 0 0 0 0 0 0 0 0
1 0FF0000F 0 31 0 0 0 0 0 0 0 0 0 0 0 0
1 00000073 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 023110BB 2 3 1 0 0 0 0 0 0 0 0 0 0 0
0 FFFFFFFF 2 3 1 0 0 0 0 0 0 0 0 0 0 0
1 003100B3 2 3 1 0 1 0 0 0 0 0 0 0 0 1
